/* quplsDecodeLoad.sv */
`timescale 1ns/1ns

// Sorts an instruction into the memory pipeline classes.
// Purely combinational, so the result is ready in the same cycle
module quplsDecodeLoad
(
	input quplsPkg::instrT instr,
	output logic load,
	output logic cLoad,
	output logic cLoadTags
);

	// Fields pulled out of the word
	quplsPkg::opcodeT opcode;
	quplsPkg::funcT func;

	// Ordinary loads, including the indirect call that reads its target
	function automatic logic isLoadOp(input quplsPkg::opcodeT op);
		case (op)
			quplsPkg::opLoad,
			quplsPkg::opLoadU,
			quplsPkg::opFLoad,
			quplsPkg::opDFLoad,
			quplsPkg::opPLoad,
			quplsPkg::opJsri:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// A capability load has an opcode of its own
	function automatic logic isCLoadOp(input quplsPkg::opcodeT op);
		return op == quplsPkg::opCLoad;
	endfunction

	// Load-tags lives inside the capability group and needs the function field
	function automatic logic isCLoadTagsOp(input quplsPkg::opcodeT op, input quplsPkg::funcT fn);
		if (op == quplsPkg::opCap)
		begin
			return fn == quplsPkg::fnCLoadTags;
		end
		return 1'b0;
	endfunction

	assign opcode = instr[quplsPkg::opcodeWidth-1:0];
	assign func = instr[quplsPkg::funcLsb +: quplsPkg::funcWidth];

	// The three classes are mutually exclusive by construction
	assign load = isLoadOp(opcode);
	assign cLoad = isCLoadOp(opcode);
	assign cLoadTags = isCLoadTagsOp(opcode, func);

endmodule

/* quplsDecodeRegs.sv */
`timescale 1ns/1ns

// Pulls the register specifiers out of an instruction and works out
// which of them the opcode actually reads or writes
module quplsDecodeRegs
(
	input quplsPkg::instrT instr,
	output quplsPkg::regSpecT rd,
	output quplsPkg::regSpecT rs1,
	output quplsPkg::regSpecT rs2,
	output logic rdUsed,
	output logic rs1Used,
	output logic rs2Used,
	output logic illegal
);

	quplsPkg::opcodeT opcode;
	quplsPkg::funcT func;

	assign opcode = instr[quplsPkg::opcodeWidth-1:0];
	assign func = instr[quplsPkg::funcLsb +: quplsPkg::funcWidth];

	// The fields sit at fixed places in every format, so they are
	// extracted unconditionally and the use bits say which ones matter
	assign rd = instr[quplsPkg::rdLsb +: quplsPkg::regSpecWidth];
	assign rs1 = instr[quplsPkg::rs1Lsb +: quplsPkg::regSpecWidth];
	assign rs2 = instr[quplsPkg::rs2Lsb +: quplsPkg::regSpecWidth];

	always_comb
	begin
		// Unknown until an opcode below claims the instruction
		rdUsed = 1'b0;
		rs1Used = 1'b0;
		rs2Used = 1'b0;
		illegal = 1'b1;
		case (opcode)
			// Loads write rd from the address in rs1
			quplsPkg::opLoad,
			quplsPkg::opLoadU,
			quplsPkg::opFLoad,
			quplsPkg::opDFLoad,
			quplsPkg::opPLoad,
			quplsPkg::opJsri,
			quplsPkg::opCLoad:
			begin
				rdUsed = 1'b1;
				rs1Used = 1'b1;
				illegal = 1'b0;
			end
			// Only load-tags is defined in the capability group so far
			quplsPkg::opCap:
			begin
				if (func == quplsPkg::fnCLoadTags)
				begin
					rdUsed = 1'b1;
					rs1Used = 1'b1;
					illegal = 1'b0;
				end
			end
			// Stores read the address and the data and write nothing
			quplsPkg::opStore:
			begin
				rs1Used = 1'b1;
				rs2Used = 1'b1;
				illegal = 1'b0;
			end
			// Two sources and one destination
			quplsPkg::opAlu:
			begin
				rdUsed = 1'b1;
				rs1Used = 1'b1;
				rs2Used = 1'b1;
				illegal = 1'b0;
			end
			default:
			begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

/* quplsDecodeStage.sv */
`timescale 1ns/1ns

// Second pipeline stage. Decodes the latched instruction and registers
// every result alongside its valid and tag
module quplsDecodeStage
(
	input logic clk,
	input logic rstN,
	input logic flush,
	input quplsPkg::instrT s1Instr,
	input logic s1Valid,
	input quplsPkg::seqTagT s1Tag,
	output logic decValid,
	output quplsPkg::seqTagT decTag,
	output logic isLoad,
	output logic isCLoad,
	output logic isCLoadTags,
	output quplsPkg::regSpecT rd,
	output quplsPkg::regSpecT rs1,
	output quplsPkg::regSpecT rs2,
	output logic rdUsed,
	output logic rs1Used,
	output logic rs2Used,
	output logic illegal
);

	// ======================================================================
	// Combinational decode
	// ======================================================================

	logic nxtLoad;
	logic nxtCLoad;
	logic nxtCLoadTags;
	quplsPkg::regSpecT nxtRd;
	quplsPkg::regSpecT nxtRs1;
	quplsPkg::regSpecT nxtRs2;
	logic nxtRdUsed;
	logic nxtRs1Used;
	logic nxtRs2Used;
	logic nxtIllegal;

	// Memory pipeline class
	quplsDecodeLoad uLoad
	(
		.instr(s1Instr),
		.load(nxtLoad),
		.cLoad(nxtCLoad),
		.cLoadTags(nxtCLoadTags)
	);

	// Register specifiers and legality
	quplsDecodeRegs uRegs
	(
		.instr(s1Instr),
		.rd(nxtRd),
		.rs1(nxtRs1),
		.rs2(nxtRs2),
		.rdUsed(nxtRdUsed),
		.rs1Used(nxtRs1Used),
		.rs2Used(nxtRs2Used),
		.illegal(nxtIllegal)
	);

	// ======================================================================
	// Output register
	// ======================================================================

	// Flush kills whatever was sitting in stage one
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			decValid <= 1'b0;
		else
			decValid <= s1Valid & ~flush;
	end

	// Results are only meaningful while decValid is high
	always_ff @(posedge clk)
	begin
		if (s1Valid)
		begin
			decTag <= s1Tag;
			isLoad <= nxtLoad;
			isCLoad <= nxtCLoad;
			isCLoadTags <= nxtCLoadTags;
			rd <= nxtRd;
			rs1 <= nxtRs1;
			rs2 <= nxtRs2;
			rdUsed <= nxtRdUsed;
			rs1Used <= nxtRs1Used;
			rs2Used <= nxtRs2Used;
			illegal <= nxtIllegal;
		end
	end

endmodule

/* quplsDecoder.f */
quplsPkg.sv
quplsDecodeLoad.sv
quplsDecodeRegs.sv
quplsInstrLatch.sv
quplsDecodeStage.sv
quplsDecoder.sv
quplsDecoderTb.sv

/* quplsDecoder.sv */
`timescale 1ns/1ns

// Decoder front end. Two register stages, so an instruction accepted
// at one edge shows up on the outputs two edges later
module quplsDecoder
(
	input logic clk,
	input logic rstN,
	input quplsPkg::instrT instr,
	input logic instrValid,
	input logic flush,
	output logic decValid,
	output quplsPkg::seqTagT decTag,
	output logic isLoad,
	output logic isCLoad,
	output logic isCLoadTags,
	output quplsPkg::regSpecT rd,
	output quplsPkg::regSpecT rs1,
	output quplsPkg::regSpecT rs2,
	output logic rdUsed,
	output logic rs1Used,
	output logic rs2Used,
	output logic illegal
);

	// Stage one to stage two
	quplsPkg::instrT s1Instr;
	logic s1Valid;
	quplsPkg::seqTagT s1Tag;

	// Capture and tagging
	quplsInstrLatch uLatch
	(
		.clk(clk),
		.rstN(rstN),
		.flush(flush),
		.instr(instr),
		.instrValid(instrValid),
		.s1Instr(s1Instr),
		.s1Valid(s1Valid),
		.s1Tag(s1Tag)
	);

	// Decode and output register
	quplsDecodeStage uDecode
	(
		.clk(clk),
		.rstN(rstN),
		.flush(flush),
		.s1Instr(s1Instr),
		.s1Valid(s1Valid),
		.s1Tag(s1Tag),
		.decValid(decValid),
		.decTag(decTag),
		.isLoad(isLoad),
		.isCLoad(isCLoad),
		.isCLoadTags(isCLoadTags),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.rdUsed(rdUsed),
		.rs1Used(rs1Used),
		.rs2Used(rs2Used),
		.illegal(illegal)
	);

endmodule

/* quplsDecoderTb.sv */
`timescale 1ns/1ns

module quplsDecoderTb;

	localparam int maxTests = 32;
	localparam int clkPeriod = 4;

	// Expected outputs packed as {isLoad, isCLoad, isCLoadTags, rdUsed, rs1Used, rs2Used, illegal}
	localparam logic [6:0] expLoad = 7'b1001100;
	localparam logic [6:0] expCLoad = 7'b0101100;
	localparam logic [6:0] expCTags = 7'b0011100;
	localparam logic [6:0] expStore = 7'b0000110;
	localparam logic [6:0] expAlu = 7'b0001110;
	localparam logic [6:0] expIllegal = 7'b0000001;
	localparam logic [6:0] expNone = 7'b0000000;

	logic clk;
	logic rstN;
	quplsPkg::instrT instr;
	logic instrValid;
	logic flush;
	logic decValid;
	quplsPkg::seqTagT decTag;
	logic isLoad;
	logic isCLoad;
	logic isCLoadTags;
	quplsPkg::regSpecT rd;
	quplsPkg::regSpecT rs1;
	quplsPkg::regSpecT rs2;
	logic rdUsed;
	logic rs1Used;
	logic rs2Used;
	logic illegal;

	// ======================================================================
	// Stimulus table, one row per cycle of input
	// ======================================================================
	string tName [maxTests];
	quplsPkg::instrT tInstr [maxTests];
	logic tValid [maxTests];
	logic tFlush [maxTests];
	logic [6:0] tExpect [maxTests];
	quplsPkg::regSpecT tRd [maxTests];
	quplsPkg::regSpecT tRs1 [maxTests];
	quplsPkg::regSpecT tRs2 [maxTests];
	quplsPkg::seqTagT tTag [maxTests];
	int tCycle [maxTests];
	int numTests;
	bit tableReady;

	// Rows accepted by the DUT and not yet seen on the outputs, oldest first
	int pending [$];
	// Reference copy of the tag counter
	quplsPkg::seqTagT nextTag;
	int cycleCnt;
	integer seed;
	int testErrs;
	int passCount;
	int failCount;
	int otherErrs;

	quplsDecoder i_dut
	(
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.instrValid(instrValid),
		.flush(flush),
		.decValid(decValid),
		.decTag(decTag),
		.isLoad(isLoad),
		.isCLoad(isCLoad),
		.isCLoadTags(isCLoadTags),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.rdUsed(rdUsed),
		.rs1Used(rs1Used),
		.rs2Used(rs2Used),
		.illegal(illegal)
	);

	always #2 clk = ~clk;

	// Counts rising edges so that latency can be measured
	always @(posedge clk)
		cycleCnt <= cycleCnt + 1;

	// Register fields are random, opcode and function come from the row
	task automatic addEntry(input string name, input quplsPkg::opcodeT op,
			input quplsPkg::funcT fn, input logic vld, input logic fl, input logic [6:0] expBits);
		logic [31:0] r;
		r = $random(seed);
		tName[numTests] = name;
		tRd[numTests] = r[5:0];
		tRs1[numTests] = r[11:6];
		tRs2[numTests] = r[17:12];
		tInstr[numTests] = {fn, tRs2[numTests], tRs1[numTests], tRd[numTests], op};
		tValid[numTests] = vld;
		tFlush[numTests] = fl;
		tExpect[numTests] = expBits;
		numTests++;
	endtask

	task automatic buildTable();
		numTests = 0;
		addEntry("load", quplsPkg::opLoad, 7'h00, 1'b1, 1'b0, expLoad);
		addEntry("loadU", quplsPkg::opLoadU, 7'h3c, 1'b1, 1'b0, expLoad);
		addEntry("fLoad", quplsPkg::opFLoad, 7'h00, 1'b1, 1'b0, expLoad);
		addEntry("dfLoad", quplsPkg::opDFLoad, 7'h01, 1'b1, 1'b0, expLoad);
		addEntry("pLoad", quplsPkg::opPLoad, 7'h00, 1'b1, 1'b0, expLoad);
		addEntry("jsri", quplsPkg::opJsri, 7'h00, 1'b1, 1'b0, expLoad);
		addEntry("cLoad", quplsPkg::opCLoad, 7'h00, 1'b1, 1'b0, expCLoad);
		addEntry("cLoadTags", quplsPkg::opCap, quplsPkg::fnCLoadTags, 1'b1, 1'b0, expCTags);
		addEntry("capOther", quplsPkg::opCap, 7'h05, 1'b1, 1'b0, expIllegal);
		// The load-tags function value on a store must not leak into the class
		addEntry("store", quplsPkg::opStore, quplsPkg::fnCLoadTags, 1'b1, 1'b0, expStore);
		addEntry("alu", quplsPkg::opAlu, 7'h00, 1'b1, 1'b0, expAlu);
		addEntry("idle0", quplsPkg::opLoad, 7'h00, 1'b0, 1'b0, expNone);
		addEntry("unknown7f", 7'h7f, 7'h00, 1'b1, 1'b0, expIllegal);
		addEntry("unknown00", 7'h00, 7'h00, 1'b1, 1'b0, expIllegal);
		addEntry("idle1", quplsPkg::opAlu, 7'h00, 1'b0, 1'b0, expNone);
		addEntry("alu2", quplsPkg::opAlu, 7'h2a, 1'b1, 1'b0, expAlu);
		addEntry("load2", quplsPkg::opLoad, 7'h00, 1'b1, 1'b0, expLoad);
		addEntry("storeFlushed", quplsPkg::opStore, 7'h00, 1'b1, 1'b0, expStore);
		addEntry("flushWithInstr", quplsPkg::opAlu, 7'h00, 1'b1, 1'b1, expAlu);
		addEntry("loadAfterFlush", quplsPkg::opLoad, 7'h00, 1'b1, 1'b0, expLoad);
		addEntry("cLoad2", quplsPkg::opCLoad, 7'h11, 1'b1, 1'b0, expCLoad);
		addEntry("idle2", quplsPkg::opLoad, 7'h00, 1'b0, 1'b0, expNone);
		addEntry("capOther2", quplsPkg::opCap, 7'h7f, 1'b1, 1'b0, expIllegal);
		addEntry("alu3", quplsPkg::opAlu, 7'h00, 1'b1, 1'b0, expAlu);
		addEntry("jsri2", quplsPkg::opJsri, 7'h00, 1'b1, 1'b0, expLoad);
		addEntry("pLoadFlushed", quplsPkg::opPLoad, 7'h00, 1'b1, 1'b0, expLoad);
		addEntry("flushIdle", quplsPkg::opLoad, 7'h00, 1'b0, 1'b1, expNone);
		addEntry("store2", quplsPkg::opStore, 7'h00, 1'b1, 1'b0, expStore);
		addEntry("unknown33", 7'h33, 7'h00, 1'b1, 1'b0, expIllegal);
	endtask

	// ======================================================================
	// Compare tasks
	// ======================================================================
	task automatic checkFlag(input string name, input string field, input logic expV,
			input logic actV);
		if (expV !== actV)
		begin
			$display("CHECK FAILED %s %s: expected %0b, actual %0b", name, field, expV, actV);
			testErrs++;
		end
	endtask

	task automatic checkReg(input string name, input string field,
			input quplsPkg::regSpecT expV, input quplsPkg::regSpecT actV);
		if (expV !== actV)
		begin
			$display("CHECK FAILED %s %s: expected %0d, actual %0d", name, field, expV, actV);
			testErrs++;
		end
	endtask

	task automatic checkTag(input string name, input quplsPkg::seqTagT expV,
			input quplsPkg::seqTagT actV);
		if (expV !== actV)
		begin
			$display("CHECK FAILED %s decTag: expected %0d, actual %0d", name, expV, actV);
			testErrs++;
		end
	endtask

	task automatic checkLatency(input string name, input int expV, input int actV);
		if (expV != actV)
		begin
			$display("CHECK FAILED %s latency: expected edge %0d, actual edge %0d",
				name, expV, actV);
			testErrs++;
		end
	endtask

	// Outputs settle after the rising edge, so they are read at the falling one
	task automatic sampleOutputs();
		int idx;
		if (decValid && pending.size() == 0)
		begin
			$display("ERROR: decValid is high with tag %0d but no instruction is in flight", decTag);
			otherErrs++;
		end
		else if (decValid)
		begin
			idx = pending.pop_front();
			testErrs = 0;
			checkFlag(tName[idx], "isLoad", tExpect[idx][6], isLoad);
			checkFlag(tName[idx], "isCLoad", tExpect[idx][5], isCLoad);
			checkFlag(tName[idx], "isCLoadTags", tExpect[idx][4], isCLoadTags);
			checkFlag(tName[idx], "rdUsed", tExpect[idx][3], rdUsed);
			checkFlag(tName[idx], "rs1Used", tExpect[idx][2], rs1Used);
			checkFlag(tName[idx], "rs2Used", tExpect[idx][1], rs2Used);
			checkFlag(tName[idx], "illegal", tExpect[idx][0], illegal);
			checkReg(tName[idx], "rd", tRd[idx], rd);
			checkReg(tName[idx], "rs1", tRs1[idx], rs1);
			checkReg(tName[idx], "rs2", tRs2[idx], rs2);
			checkTag(tName[idx], tTag[idx], decTag);
			// Captured at the first edge, registered at the second
			checkLatency(tName[idx], tCycle[idx] + 2, cycleCnt);
			if (testErrs == 0)
				passCount++;
			else
				failCount++;
			$display("%-16s tag %2d finished, %0d mismatches", tName[idx], tTag[idx], testErrs);
		end
	endtask

	task automatic driveEntry(input int idx);
		int j;
		instr = tInstr[idx];
		instrValid = tValid[idx];
		flush = tFlush[idx];
		if (tFlush[idx])
		begin
			// What is left in the queue sits in stage one and dies at the next edge
			while (pending.size() > 0)
			begin
				j = pending.pop_front();
				$display("%-16s finished, flushed before decode", tName[j]);
				passCount++;
			end
		end
		if (tValid[idx] && !tFlush[idx])
		begin
			// Tag is the counter value at acceptance, then the counter moves on
			tTag[idx] = nextTag;
			nextTag = nextTag + 1'b1;
			tCycle[idx] = cycleCnt;
			pending.push_back(idx);
		end
		else
		begin
			$display("%-16s finished, nothing accepted", tName[idx]);
			passCount++;
		end
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		flush = 1'b0;
		cycleCnt = 0;
		seed = 32'h1788;
		nextTag = '0;
		passCount = 0;
		failCount = 0;
		otherErrs = 0;
		buildTable();
		tableReady = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		for (int i = 0; i < numTests; i++)
		begin
			@(negedge clk);
			sampleOutputs();
			driveEntry(i);
		end
		// Drain the pipeline with the inputs idle
		repeat (4)
		begin
			@(negedge clk);
			sampleOutputs();
			instrValid = 1'b0;
			flush = 1'b0;
		end
		if (pending.size() != 0)
		begin
			$display("ERROR: %0d accepted instructions never reached the outputs", pending.size());
			otherErrs++;
		end
		$display("Summary: %0d passed, %0d failed, %0d other errors", passCount, failCount,
			otherErrs);
		if (failCount == 0 && otherErrs == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Watchdog, sized from the table with room for reset and draining
	initial
	begin
		wait (tableReady);
		#((numTests + 20) * clkPeriod);
		$display("Timeout: the run did not finish within %0d cycles", numTests + 20);
		$display("Test failed");
		$finish;
	end

endmodule

/* quplsInstrLatch.sv */
`timescale 1ns/1ns

// First pipeline register. Captures each accepted instruction and
// stamps it with the next sequence tag
module quplsInstrLatch
(
	input logic clk,
	input logic rstN,
	input logic flush,
	input quplsPkg::instrT instr,
	input logic instrValid,
	output quplsPkg::instrT s1Instr,
	output logic s1Valid,
	output quplsPkg::seqTagT s1Tag
);

	// Next tag to hand out
	quplsPkg::seqTagT tagCnt;
	logic accept;

	// An instruction offered together with a flush is thrown away
	assign accept = instrValid & ~flush;

	// Control state
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			s1Valid <= 1'b0;
			tagCnt <= '0;
		end
		else
		begin
			s1Valid <= accept;
			// The counter keeps its value across a flush and wraps at sixteen
			if (accept)
			begin
				tagCnt <= tagCnt + 1'b1;
			end
		end
	end

	// Instruction word and its tag only change when something is accepted
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			s1Instr <= instr;
			s1Tag <= tagCnt;
		end
	end

endmodule

/* quplsPkg.sv */
// ======================================================================
// Shared widths, types and encodings for the decoder front end
// ======================================================================
package quplsPkg;

	// Width of one instruction word as it arrives from fetch
	localparam int instrWidth = 32;

	// The primary opcode occupies the lowest bits of the word
	localparam int opcodeWidth = 7;

	// Capability instructions carry a secondary function field at the top
	localparam int funcWidth = 7;

	// The register file holds 64 entries, so each specifier is six bits wide
	localparam int regSpecWidth = 6;

	// Sequence tags wrap after sixteen instructions
	localparam int seqTagWidth = 4;

	// ======================================================================
	// Vector types
	// ======================================================================

	// A raw instruction word
	typedef logic [instrWidth-1:0] instrT;

	// The primary opcode field, bits 6 down to 0
	typedef logic [opcodeWidth-1:0] opcodeT;

	// The capability function field, bits 31 down to 25
	typedef logic [funcWidth-1:0] funcT;

	// One register number
	typedef logic [regSpecWidth-1:0] regSpecT;

	// Tag that follows an instruction through the pipeline
	typedef logic [seqTagWidth-1:0] seqTagT;

	// ======================================================================
	// Field positions
	// ======================================================================

	// Low bit of the destination specifier
	localparam int rdLsb = 7;

	// Low bit of the first source specifier
	localparam int rs1Lsb = 13;

	// Low bit of the second source specifier
	localparam int rs2Lsb = 19;

	// Low bit of the capability function field
	localparam int funcLsb = 25;

	// ======================================================================
	// Opcodes
	// ======================================================================

	// Integer loads, signed and unsigned
	localparam opcodeT opLoad = 7'h40;
	localparam opcodeT opLoadU = 7'h41;

	// Floating point loads in single and double width
	localparam opcodeT opFLoad = 7'h42;
	localparam opcodeT opDFLoad = 7'h43;

	// Posit load
	localparam opcodeT opPLoad = 7'h44;

	// Indirect subroutine call reads its target from memory,
	// so the memory pipeline treats it as a load
	localparam opcodeT opJsri = 7'h45;

	// Load of a full capability from memory
	localparam opcodeT opCLoad = 7'h46;

	// Integer store
	localparam opcodeT opStore = 7'h48;

	// Capability group, qualified by the function field
	localparam opcodeT opCap = 7'h50;

	// Register to register arithmetic
	localparam opcodeT opAlu = 7'h04;

	// ======================================================================
	// Capability functions
	// ======================================================================

	// Loads the tag bits of a block of capabilities
	localparam funcT fnCLoadTags = 7'h12;

endpackage

/* runSim.sh */
#!/bin/sh
# Builds the decoder testbench with Verilator, runs it and checks the log

LOG=sim.log

verilator --binary --timing --top-module quplsDecoderTb -f quplsDecoder.f -o simDecoder \
	|| { echo "Build failed"; exit 1; }

./obj_dir/simDecoder > "$LOG" 2>&1
cat "$LOG"

# Any failure in the run prints the fail message
grep -q "Test failed" "$LOG" && { echo "Simulation failed"; exit 1; }

# A run that stopped without a verdict counts as a failure too
grep -q "Test passed" "$LOG" || { echo "No verdict in $LOG"; exit 1; }

echo "Simulation passed"
exit 0
